// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_abr_coef_stream
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF -- "$(PASS_MSG)" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb.f
+incdir+verilog
verilog/abr_msg_pkg.sv
verilog/abr_msg_buffer.sv
verilog/abr_coef_reduce_lane.sv
verilog/abr_coef_collector.sv
verilog/abr_coef_stream_top.sv
tb/tb_abr_coef_stream.sv

// File: tb/tb_abr_coef_stream.sv
//--------------------------------------------------------------------------
// Testbench for the coefficient stream stage with random samples, a queue
// of reduced values and assertions on every output beat
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "abr_msg_defines.svh"

module tb_abr_coef_stream;

  // Cycles allowed for any single wait loop
  localparam int TIMEOUT = 5000;

  logic                                       clk;
  logic                                       rst_b;
  logic                                       flush_i;
  logic                                       hold_i;
  logic [`ABR_MSG_NUM_WR-1:0]                 sample_valid_i;
  abr_msg_pkg::sample_t [`ABR_MSG_NUM_WR-1:0] samples_i;
  logic                                       full_o;
  abr_msg_pkg::beat_t                         beat_o;
  logic                                       poly_done_o;

  // Reduced values of accepted samples, oldest first
  int unsigned exp_q[$];

  integer seed = 32'h9cf5e39f;

  // Monitor counters, and the separate count for the stimulus process
  int errors = 0;
  int run_errors = 0;
  int checks = 0;
  int n_acc = 0;
  int n_checked = 0;
  int n_partial = 0;
  int poly_cnt = 0;
  int cur_len = 0;

  bit                 will_accept = 1'b0;
  bit                 flush_mode = 1'b0;
  bit                 have_prev = 1'b0;
  bit                 prev_hold;
  logic               prev_done;
  abr_msg_pkg::beat_t prev_beat;

  abr_coef_stream_top i_dut (
    .clk            (clk),
    .rst_b          (rst_b),
    .flush_i        (flush_i),
    .hold_i         (hold_i),
    .sample_valid_i (sample_valid_i),
    .samples_i      (samples_i),
    .full_o         (full_o),
    .beat_o         (beat_o),
    .poly_done_o    (poly_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A sample below 2q loses q once when it is at least q
  function automatic int unsigned reduce_mod_q(input int unsigned s);
    if (s >= `ABR_MSG_Q) begin
      return s - `ABR_MSG_Q;
    end
    return s;
  endfunction

  task automatic report_check(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic report_run(input string msg);
    run_errors++;
    $display("%s", msg);
  endtask

  // Checks one fresh output beat for mask shape, value order and the done flag
  task automatic check_beat();
    int                         pc;
    int unsigned                exp_coef;
    logic                       exp_done;
    logic [`ABR_MSG_NUM_RD-1:0] exp_mask;
    pc = $countones(beat_o.valid);
    checks++;
    if (!flush_mode) begin
      assert (pc == 0 || pc == `ABR_MSG_NUM_RD) else
        report_check($sformatf("mismatch beat_o.valid exp %h act %h", 4'hf, beat_o.valid));
    end else begin
      // A flushed beat still fills its lanes from lane 0 upwards
      exp_mask = `ABR_MSG_NUM_RD'((1 << pc) - 1);
      assert (beat_o.valid == exp_mask) else
        report_check($sformatf("mismatch beat_o.valid exp %h act %h",
                               exp_mask, beat_o.valid));
      if (pc != 0 && pc != `ABR_MSG_NUM_RD) begin
        n_partial++;
      end
    end
    for (int i = 0; i < `ABR_MSG_NUM_RD; i++) begin
      if (beat_o.valid[i]) begin
        checks++;
        if (exp_q.size() == 0) begin
          report_check("beat_o carries a coefficient that was never accepted");
        end else begin
          exp_coef = exp_q.pop_front();
          assert (beat_o.coef[i] === abr_msg_pkg::coef_t'(exp_coef)) else
            report_check($sformatf("mismatch beat_o.coef[%0d] exp %h act %h",
                                   i, exp_coef, beat_o.coef[i]));
          n_checked++;
        end
      end
    end
    // Done goes with the beat that takes the count past 256
    poly_cnt += pc;
    exp_done = 1'b0;
    if (poly_cnt >= `ABR_MSG_N_COEF) begin
      poly_cnt -= `ABR_MSG_N_COEF;
      exp_done = 1'b1;
    end
    checks++;
    assert (poly_done_o === exp_done) else
      report_check($sformatf("mismatch poly_done_o exp %h act %h", exp_done, poly_done_o));
  endtask

  // Outputs and inputs are all settled half a cycle after the edge
  always @(negedge clk) begin
    if (!rst_b) begin
      have_prev   = 1'b0;
      will_accept = 1'b0;
    end else begin
      if (!have_prev) begin
        checks++;
        assert (beat_o.valid == '0) else
          report_check($sformatf("mismatch beat_o.valid exp 0 act %h", beat_o.valid));
        assert (poly_done_o == 1'b0) else
          report_check($sformatf("mismatch poly_done_o exp 0 act %h", poly_done_o));
        assert (full_o == 1'b0) else
          report_check($sformatf("mismatch full_o exp 0 act %h", full_o));
      end else if (prev_hold) begin
        checks++;
        assert (beat_o === prev_beat) else
          report_check($sformatf("mismatch beat_o exp %h act %h", prev_beat, beat_o));
        assert (poly_done_o === prev_done) else
          report_check($sformatf("mismatch poly_done_o exp %h act %h", prev_done, poly_done_o));
      end else begin
        check_beat();
      end
      // The next edge takes these samples unless the buffer is full
      will_accept = (|sample_valid_i) && !full_o;
      if (will_accept) begin
        for (int i = 0; i < `ABR_MSG_NUM_WR; i++) begin
          if (sample_valid_i[i]) begin
            exp_q.push_back(reduce_mod_q(int'(samples_i[i])));
            n_acc++;
          end
        end
      end
      prev_hold = hold_i;
      prev_beat = beat_o;
      prev_done = poly_done_o;
      have_prev = 1'b1;
    end
  end

  // New samples only once the last ones went in, otherwise repeat them
  task automatic drive_cycle(input int hold_pct, input int fixed_len, input bit flush);
    int len;
    @(posedge clk);
    if (cur_len == 0 || will_accept) begin
      if (fixed_len < 0) begin
        len = int'($unsigned($random(seed)) % 6);
      end else begin
        len = fixed_len;
      end
      cur_len = len;
      sample_valid_i <= 5'((6'd1 << len) - 6'd1);
      for (int i = 0; i < `ABR_MSG_NUM_WR; i++) begin
        samples_i[i] <= abr_msg_pkg::sample_t'($random(seed));
      end
    end
    hold_i  <= int'($unsigned($random(seed)) % 100) < hold_pct;
    flush_i <= flush;
  endtask

  task automatic run_stream(input string name, input int target, input int hold_pct);
    int start;
    int cycles;
    start  = n_checked;
    cycles = 0;
    while (n_checked - start < target && cycles < TIMEOUT) begin
      drive_cycle(hold_pct, -1, 1'b0);
      cycles++;
    end
    if (n_checked - start < target) begin
      report_run($sformatf("timeout in phase %s after %0d cycles", name, cycles));
    end
    $display("phase %s: %0d coefficients checked, %0d errors",
             name, n_checked - start, errors + run_errors);
  endtask

  // Stop the source once the current samples are in
  task automatic drain_source();
    int cycles;
    cycles = 0;
    drive_cycle(0, 0, 1'b0);
    while (cur_len != 0 && cycles < TIMEOUT) begin
      drive_cycle(0, 0, 1'b0);
      cycles++;
    end
    if (cur_len != 0) begin
      report_run("timeout while the source waited for the buffer");
    end
  endtask

  task automatic wait_queue(input int level);
    int cycles;
    cycles = 0;
    while (exp_q.size() != level && cycles < TIMEOUT) begin
      drive_cycle(0, 0, 1'b0);
      cycles++;
    end
    if (exp_q.size() != level) begin
      report_run($sformatf("timeout waiting for %0d pending samples", level));
    end
  endtask

  // Leave one to three samples behind, then flush them out
  task automatic run_flush();
    int rem;
    drain_source();
    drive_cycle(0, (n_acc % `ABR_MSG_NUM_RD == 3) ? 2 : 1, 1'b0);
    drain_source();
    rem = n_acc % `ABR_MSG_NUM_RD;
    wait_queue(rem);
    flush_mode = 1'b1;
    drive_cycle(0, 0, 1'b1);
    wait_queue(0);
    assert (n_partial == 1) else
      report_run($sformatf("flush gave %0d partial beats instead of one", n_partial));
    assert (exp_q.size() == 0) else
      report_run($sformatf("%0d samples never left the stage", exp_q.size()));
    $display("phase flush: %0d samples left, %0d partial beat, %0d errors",
             rem, n_partial, errors + run_errors);
  endtask

  initial begin
    rst_b          = 1'b0;
    flush_i        = 1'b0;
    hold_i         = 1'b0;
    sample_valid_i = '0;
    samples_i      = '0;
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
    run_stream("steady stream", 600, 25);
    run_stream("heavy hold", 200, 75);
    run_flush();
    $display("checks %0d, coefficients %0d, errors %0d",
             checks, n_checked, errors + run_errors);
    if (errors + run_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog/abr_coef_collector.sv
//--------------------------------------------------------------------------
// Collector: registers lane results as an output beat and flags each
// completed polynomial of 256 coefficients
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "abr_msg_defines.svh"

module abr_coef_collector (
  input  logic                                        clk,
  input  logic                                        rst_b,
  input  logic                                        hold_i,
  input  abr_msg_pkg::lane_out_t [`ABR_MSG_NUM_RD-1:0] lanes_i,
  output abr_msg_pkg::beat_t                          beat_o,
  output logic                                        poly_done_o
);

  logic [`ABR_MSG_NUM_RD-1:0]                  valid_q;
  abr_msg_pkg::coef_t [`ABR_MSG_NUM_RD-1:0]    coef_q;
  logic                                        done_q;

  // Counter needs one extra bit to see the crossing of N_COEF
  logic [$clog2(`ABR_MSG_N_COEF):0] cnt_q;
  logic [$clog2(`ABR_MSG_N_COEF):0] cnt_sum;
  logic [$clog2(`ABR_MSG_NUM_RD):0] pop_cnt;

  // Coefficients carried by the beat being captured
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `ABR_MSG_NUM_RD; i++) begin
      pop_cnt = pop_cnt + ($clog2(`ABR_MSG_NUM_RD)+1)'(lanes_i[i].valid);
    end
    cnt_sum = cnt_q + ($clog2(`ABR_MSG_N_COEF)+1)'(pop_cnt);
  end

  // Done lines up with the beat that completes the polynomial
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else if (!hold_i) begin
      for (int i = 0; i < `ABR_MSG_NUM_RD; i++) begin
        valid_q[i] <= lanes_i[i].valid;
      end
      if (cnt_sum >= ($clog2(`ABR_MSG_N_COEF)+1)'(`ABR_MSG_N_COEF)) begin
        cnt_q  <= cnt_sum - ($clog2(`ABR_MSG_N_COEF)+1)'(`ABR_MSG_N_COEF);
        done_q <= 1'b1;
      end else begin
        cnt_q  <= cnt_sum;
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      for (int i = 0; i < `ABR_MSG_NUM_RD; i++) begin
        coef_q[i] <= lanes_i[i].coef;
      end
    end
  end

  always_comb begin
    beat_o.valid = valid_q;
    beat_o.coef  = coef_q;
    poly_done_o  = done_q;
  end

  // Buffer pops are prefixes, and the lanes keep that through two stages
  a_beat_prefix: assert property (@(posedge clk) disable iff (!rst_b)
    (beat_o.valid & `ABR_MSG_NUM_RD'(beat_o.valid + 1'b1)) == '0);

  // Every coefficient leaving the stage must be fully reduced by its lane
  for (genvar i = 0; i < `ABR_MSG_NUM_RD; i++) begin : g_chk
    a_coef_below_q: assert property (@(posedge clk) disable iff (!rst_b)
      beat_o.valid[i] |-> (32'(beat_o.coef[i]) < `ABR_MSG_Q));
  end

endmodule

// File: verilog/abr_coef_reduce_lane.sv
//--------------------------------------------------------------------------
// Reduction lane with one registered conditional subtraction of q
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "abr_msg_defines.svh"

module abr_coef_reduce_lane (
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic                  hold_i,
  input  abr_msg_pkg::lane_in_t  lane_i,
  output abr_msg_pkg::lane_out_t lane_o
);

  logic                 ge_q;
  abr_msg_pkg::coef_t   coef_d;
  abr_msg_pkg::coef_t   coef_q;
  logic                 valid_q;

  // Input is below 2q, so one subtraction is enough
  always_comb begin
    ge_q = lane_i.sample >= abr_msg_pkg::sample_t'(`ABR_MSG_Q);
    if (ge_q) begin
      coef_d = lane_i.sample - abr_msg_pkg::sample_t'(`ABR_MSG_Q);
    end else begin
      coef_d = lane_i.sample;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      valid_q <= lane_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      coef_q <= coef_d;
    end
  end

  always_comb begin
    lane_o.valid = valid_q;
    lane_o.coef  = coef_q;
  end

endmodule

// File: verilog/abr_coef_stream_top.sv
//--------------------------------------------------------------------------
// Coefficient stream stage: message buffer, four mod-q lanes, collector
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "abr_msg_defines.svh"

module abr_coef_stream_top (
  input  logic                                       clk,
  input  logic                                       rst_b,
  input  logic                                       flush_i,
  input  logic                                       hold_i,
  input  logic [`ABR_MSG_NUM_WR-1:0]                 sample_valid_i,
  input  abr_msg_pkg::sample_t [`ABR_MSG_NUM_WR-1:0] samples_i,
  output logic                                       full_o,
  output abr_msg_pkg::beat_t                         beat_o,
  output logic                                       poly_done_o
);

  // Popped samples, valid only in the cycle of the pop
  abr_msg_pkg::lane_in_t  [`ABR_MSG_NUM_RD-1:0] lane_in;

  // Reduced coefficients, one stage after the pop
  abr_msg_pkg::lane_out_t [`ABR_MSG_NUM_RD-1:0] lane_out;

  abr_msg_buffer i_msg_buffer (
    .clk           (clk),
    .rst_b         (rst_b),
    .flush_i       (flush_i),
    .data_valid_i  (sample_valid_i),
    .data_i        (samples_i),
    .data_hold_i   (hold_i),
    .buffer_full_o (full_o),
    .lane_o        (lane_in)
  );

  // Hold freezes every lane together with the buffer and collector
  for (genvar i = 0; i < `ABR_MSG_NUM_RD; i++) begin : g_lane
    abr_coef_reduce_lane i_lane (
      .clk    (clk),
      .rst_b  (rst_b),
      .hold_i (hold_i),
      .lane_i (lane_in[i]),
      .lane_o (lane_out[i])
    );
  end

  abr_coef_collector i_collector (
    .clk         (clk),
    .rst_b       (rst_b),
    .hold_i      (hold_i),
    .lanes_i     (lane_out),
    .beat_o      (beat_o),
    .poly_done_o (poly_done_o)
  );

endmodule

// File: verilog/abr_msg_buffer.sv
//--------------------------------------------------------------------------
// Message buffer: packs up to NUM_WR contiguous samples per cycle into
// beats of NUM_RD lanes, with full, hold and flush handling
//--------------------------------------------------------------------------

`timescale 1ns/10ps

`include "abr_msg_defines.svh"

module abr_msg_buffer #(
  parameter int NUM_WR = `ABR_MSG_NUM_WR,
  parameter int NUM_RD = `ABR_MSG_NUM_RD,
  parameter int DATA_W = `ABR_MSG_DATA_W
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                flush_i,
  input  logic [NUM_WR-1:0]                   data_valid_i,
  input  logic [NUM_WR-1:0][DATA_W-1:0]       data_i,
  input  logic                                data_hold_i,
  output logic                                buffer_full_o,
  output abr_msg_pkg::lane_in_t [NUM_RD-1:0]  lane_o
);

  // Enough room for one pending beat plus one full input cycle
  localparam int DEPTH = NUM_WR + NUM_RD;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  logic buffer_rd;
  logic buffer_wr;

  // Entry 0 is the oldest sample and leaves first
  logic [DEPTH-1:0][DATA_W-1:0] buffer_q;
  logic [DEPTH-1:0][DATA_W-1:0] buffer_shift;
  logic [DEPTH-1:0][DATA_W-1:0] buffer_d;
  logic [DEPTH-1:0]             valid_q;
  logic [DEPTH-1:0]             valid_shift;
  logic [DEPTH-1:0]             valid_d;

  logic [CNT_W-1:0] num_valid;
  logic [CNT_W-1:0] wr_base;

  // The buffer cannot take a whole input cycle. A pop in the same cycle
  // frees NUM_RD entries, so the threshold moves up when reading
  if (NUM_WR <= NUM_RD) begin : g_full_narrow
    always_comb buffer_full_o = valid_q[DEPTH-NUM_WR] & ~buffer_rd;
  end else begin : g_full_wide
    always_comb begin
      if (buffer_rd) begin
        buffer_full_o = valid_q[DEPTH-(NUM_WR-NUM_RD)];
      end else begin
        buffer_full_o = valid_q[DEPTH-NUM_WR];
      end
    end
  end

  // Pop a full beat, or whatever is left when flushing
  always_comb begin
    buffer_rd = ~data_hold_i & (valid_q[NUM_RD-1] | (flush_i & valid_q[0]));
  end

  // Accept any cycle with at least one sample while there is room
  always_comb buffer_wr = (|data_valid_i) & ~buffer_full_o;

  // Valid entries are a prefix, so the count is the first free slot
  always_comb begin
    num_valid = '0;
    for (int i = 0; i < DEPTH; i++) begin
      num_valid = num_valid + CNT_W'(valid_q[i]);
    end
  end

  // A flushed partial beat empties the buffer completely, so the write
  // position must not go below entry 0
  always_comb begin
    if (!buffer_rd) begin
      wr_base = num_valid;
    end else if (num_valid > CNT_W'(NUM_RD)) begin
      wr_base = num_valid - CNT_W'(NUM_RD);
    end else begin
      wr_base = '0;
    end
  end

  // Drop the popped beat by moving everything down NUM_RD entries
  always_comb begin
    buffer_shift = buffer_q;
    valid_shift  = valid_q;
    if (buffer_rd) begin
      valid_shift = valid_q >> NUM_RD;
      for (int i = 0; i < DEPTH - NUM_RD; i++) begin
        buffer_shift[i] = buffer_q[i+NUM_RD];
      end
    end
  end

  // Append the new samples right above the surviving entries
  always_comb begin
    buffer_d = buffer_shift;
    valid_d  = valid_shift;
    for (int i = 0; i < DEPTH; i++) begin
      for (int s = 0; s < NUM_WR; s++) begin
        if (buffer_wr && data_valid_i[s] && (int'(wr_base) + s == i)) begin
          buffer_d[i] = data_i[s];
          valid_d[i]  = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_q <= '0;
    end else if (buffer_rd || buffer_wr) begin
      valid_q <= valid_d;
    end
  end

  // Sample storage only matters where valid_q is set
  always_ff @(posedge clk) begin
    if (buffer_rd || buffer_wr) begin
      buffer_q <= buffer_d;
    end
  end

  // Lanes see a valid sample only in the cycle of the pop, so a held or
  // partial buffer never hands the same sample over twice
  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      lane_o[i].valid  = valid_q[i] & buffer_rd;
      lane_o[i].sample = abr_msg_pkg::sample_t'(buffer_q[i]);
    end
  end

  // Source must present its samples as a prefix from lane 0
  a_wr_prefix: assert property (@(posedge clk) disable iff (!rst_b)
    (data_valid_i & NUM_WR'(data_valid_i + 1'b1)) == '0);

  // Shift and append must keep the stored samples packed from entry 0
  a_buf_prefix: assert property (@(posedge clk) disable iff (!rst_b)
    (valid_q & DEPTH'(valid_q + 1'b1)) == '0);

endmodule

// File: verilog/abr_msg_defines.svh
//--------------------------------------------------------------------------
// Coefficient stream defines: lane counts, sample width, modulus and
// polynomial size shared by the message buffer and the reduction path
//--------------------------------------------------------------------------

`ifndef ABR_MSG_DEFINES_SVH
`define ABR_MSG_DEFINES_SVH

// Candidate samples that can arrive in one input cycle
`define ABR_MSG_NUM_WR 5

// Samples per output beat, which is also the number of reduction lanes
`define ABR_MSG_NUM_RD 4

// Width of a raw sample and of a reduced coefficient
`define ABR_MSG_DATA_W 23

// ML-DSA modulus q, fits in 23 bits
`define ABR_MSG_Q 8380417

// Coefficients in one polynomial
`define ABR_MSG_N_COEF 256

`endif

// File: verilog/abr_msg_pkg.sv
//--------------------------------------------------------------------------
// Coefficient stream types: samples, coefficients, lane and beat structs
//--------------------------------------------------------------------------

`include "abr_msg_defines.svh"

package abr_msg_pkg;

  // Raw candidate from the sampler, always below 2q
  typedef logic [`ABR_MSG_DATA_W-1:0] sample_t;

  // Coefficient after reduction, always below q
  typedef logic [`ABR_MSG_DATA_W-1:0] coef_t;

  // Input of one reduction lane, valid only in the cycle the buffer pops
  typedef struct packed {
    logic    valid;
    sample_t sample;
  } lane_in_t;

  // Registered output of one reduction lane
  typedef struct packed {
    logic  valid;
    coef_t coef;
  } lane_out_t;

  // Output beat. The valid mask is a prefix from lane 0
  typedef struct packed {
    logic [`ABR_MSG_NUM_RD-1:0] valid;
    coef_t [`ABR_MSG_NUM_RD-1:0] coef;
  } beat_t;

endpackage
